// File: logic/residuPkg.sv
package residuPkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	// Word address into the shared sample memory
	typedef logic [10:0] memAddrT;
	// Samples and Q12 coefficients
	typedef logic signed [15:0] sampleT;
	// Wide enough for eleven full-scale products
	typedef logic signed [39:0] accT;
	// APB byte address, bit 13 picks the memory window
	typedef logic [13:0] apbAddrT;
	// Frame length, 1 to maxLen
	typedef logic [6:0] lenT;
	// Coefficient and tap index, one past the last tap
	typedef logic [3:0] coefIdxT;

	localparam int memDepth = 2048;
	localparam int windowBit = 13;
	localparam int filterOrder = 10;
	localparam int maxLen = 64;
	localparam int roundShift = 12;

	////////////////////////////////////////////////////////////
	// Register map
	////////////////////////////////////////////////////////////

	localparam apbAddrT ctrlOffset = 14'h000;
	localparam apbAddrT aBaseOffset = 14'h004;
	localparam apbAddrT xBaseOffset = 14'h008;
	localparam apbAddrT yBaseOffset = 14'h00C;
	localparam apbAddrT lenOffset = 14'h010;

	// Filter engine states
	typedef enum logic [2:0] {
		idle,
		loadCoef,
		mac,
		store,
		finish
	} engineStateT;

endpackage

// File: logic/sampleRam.sv
`timescale 1ns/1ps

module sampleRam
	import residuPkg::*;
(
	input logic clk,
	input logic ramEn,
	input logic ramWe,
	input memAddrT ramAddr,
	input sampleT ramWdata,
	output sampleT ramRdata
);

	// Coefficients, history, inputs and outputs all live here
	sampleT mem [memDepth];

	// Single port, read data one cycle after the access
	always_ff @(posedge clk)
	begin
		if (ramEn)
		begin
			if (ramWe)
				mem[ramAddr] <= ramWdata;
			else
				// Output holds until the next read
				ramRdata <= mem[ramAddr];
		end
	end

endmodule

// File: logic/memArbiter.sv
`timescale 1ns/1ps

module memArbiter
	import residuPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic hostReq,
	input memAddrT hostAddr,
	input logic hostWe,
	input sampleT hostWdata,
	input logic engReq,
	input memAddrT engAddr,
	input logic engWe,
	input sampleT engWdata,
	output logic hostGnt,
	output logic engGnt,
	output logic ramEn,
	output logic ramWe,
	output memAddrT ramAddr,
	output sampleT ramWdata
);

	// Set when the host won last
	logic lastHost;

	// Lone requester wins at once and a tie goes to whoever lost last
	always_comb
	begin
		hostGnt = hostReq && (!engReq || !lastHost);
		engGnt = engReq && !hostGnt;
	end

	// Granted port drives the RAM
	always_comb
	begin
		ramEn = hostGnt || engGnt;
		ramWe = hostGnt ? hostWe : (engGnt && engWe);
		ramAddr = hostGnt ? hostAddr : engAddr;
		ramWdata = hostGnt ? hostWdata : engWdata;
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
			lastHost <= 1'b0;
		else if (hostGnt)
			lastHost <= 1'b1;
		else if (engGnt)
			lastHost <= 1'b0;
	end

	// At most one port owns the RAM
	assert property (@(posedge clk) disable iff (!rstN) !(hostGnt && engGnt));

endmodule

// File: logic/apbRegs.sv
`timescale 1ns/1ps

module apbRegs
	import residuPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic PSEL,
	input logic PENABLE,
	input logic PWRITE,
	input apbAddrT PADDR,
	input logic [31:0] PWDATA,
	input logic hostGnt,
	input sampleT ramRdata,
	input logic busy,
	input logic finish,
	output logic [31:0] PRDATA,
	output logic PREADY,
	output logic PSLVERR,
	output logic hostReq,
	output memAddrT hostAddr,
	output logic hostWe,
	output sampleT hostWdata,
	output logic start,
	output memAddrT aBase,
	output memAddrT xBase,
	output memAddrT yBase,
	output lenT len
);

	logic windowSel;
	logic regAccess;
	logic regWrite;
	logic pending;
	logic done;
	logic offsetHit;
	logic lenBad;
	logic startBad;
	logic [31:0] regRdata;

	assign windowSel = PADDR[windowBit];
	assign regAccess = PSEL && PENABLE && !windowSel;
	assign regWrite = regAccess && PWRITE;

	////////////////////////////////////////////////////////////
	// Memory window
	////////////////////////////////////////////////////////////

	// Request in the access phase until granted
	assign hostReq = PSEL && PENABLE && windowSel && !pending;
	// Word address from byte address
	assign hostAddr = PADDR[12:2];
	assign hostWe = PWRITE;
	assign hostWdata = PWDATA[15:0];

	// Granted last cycle, read data is on ramRdata now
	always_ff @(posedge clk)
	begin
		if (!rstN)
			pending <= 1'b0;
		else
			pending <= hostGnt;
	end

	////////////////////////////////////////////////////////////
	// Register decode
	////////////////////////////////////////////////////////////

	always_comb
	begin
		offsetHit = 1'b1;
		regRdata = '0;
		case (PADDR)
			// Bit 1 done, bit 0 busy
			ctrlOffset: regRdata = {30'd0, done, busy};
			aBaseOffset: regRdata = {21'd0, aBase};
			xBaseOffset: regRdata = {21'd0, xBase};
			yBaseOffset: regRdata = {21'd0, yBase};
			lenOffset: regRdata = {25'd0, len};
			default: offsetHit = 1'b0;
		endcase
	end

	// Length outside 1..maxLen
	assign lenBad = PWRITE && PADDR == lenOffset &&
		(PWDATA == 32'd0 || PWDATA > 32'(maxLen));
	// Start request on a running engine
	assign startBad = PWRITE && PADDR == ctrlOffset && PWDATA[0] && busy;
	// One-cycle pulse on the completing write
	assign start = regWrite && PADDR == ctrlOffset && PWDATA[0] && !busy;

	// Registers answer at once, window waits one cycle past its grant
	assign PREADY = PSEL && PENABLE && (!windowSel || pending);
	assign PSLVERR = regAccess && (!offsetHit || lenBad || startBad);
	assign PRDATA = windowSel ? {{16{ramRdata[15]}}, ramRdata} : regRdata;

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			aBase <= '0;
			xBase <= '0;
			yBase <= '0;
			len <= lenT'(1);
			done <= 1'b0;
		end
		else
		begin
			if (regWrite)
			begin
				case (PADDR)
					aBaseOffset: aBase <= PWDATA[10:0];
					xBaseOffset: xBase <= PWDATA[10:0];
					yBaseOffset: yBase <= PWDATA[10:0];
					// Bad length leaves the old value
					lenOffset:
						if (!lenBad)
							len <= PWDATA[6:0];
					default: ;
				endcase
			end
			// Sticky until the next frame starts
			if (start)
				done <= 1'b0;
			else if (finish)
				done <= 1'b1;
		end
	end

	// Window request and its address hold until the arbiter answers
	assert property (@(posedge clk) disable iff (!rstN)
		hostReq && !hostGnt |=> hostReq && $stable(hostAddr));

endmodule

// File: logic/residuEngine.sv
`timescale 1ns/1ps

module residuEngine
	import residuPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic start,
	input memAddrT aBase,
	input memAddrT xBase,
	input memAddrT yBase,
	input lenT len,
	input logic engGnt,
	input sampleT ramRdata,
	output logic engReq,
	output memAddrT engAddr,
	output logic engWe,
	output sampleT engWdata,
	output logic busy,
	output logic finish
);

	engineStateT state;
	// Local copy of a0..a10
	sampleT coef [filterOrder + 1];
	// Next tap to request, next tap to come back
	coefIdxT issueK;
	coefIdxT capK;
	// Output sample index
	lenT n;
	logic issueDone;
	logic rdValid;
	logic prodValid;
	logic prodLast;
	accT product;
	accT acc;

	// Round half up in Q12, then clamp to 16 bits
	function automatic sampleT roundSat(input accT value);
		accT rounded;
		rounded = (value + (accT'(1) <<< (roundShift - 1))) >>> roundShift;
		if (rounded > 40'sd32767)
			return 16'sh7fff;
		if (rounded < -40'sd32768)
			return 16'sh8000;
		return sampleT'(rounded);
	endfunction

	assign issueDone = issueK > coefIdxT'(filterOrder);
	assign busy = state != idle;
	assign finish = state == residuPkg::finish;
	assign engWdata = roundSat(acc);

	////////////////////////////////////////////////////////////
	// Address generation
	////////////////////////////////////////////////////////////

	always_comb
	begin
		engReq = 1'b0;
		engWe = 1'b0;
		// y[n] by default
		engAddr = yBase + memAddrT'(n);
		case (state)
			loadCoef:
			begin
				engReq = !issueDone;
				engAddr = aBase + memAddrT'(issueK);
			end
			mac:
			begin
				// x[n-k], the words below xBase hold history
				engReq = !issueDone;
				engAddr = xBase + memAddrT'(n) - memAddrT'(issueK);
			end
			store:
			begin
				engReq = 1'b1;
				engWe = 1'b1;
			end
			default: ;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= idle;
			issueK <= '0;
			capK <= '0;
			n <= '0;
			rdValid <= 1'b0;
			prodValid <= 1'b0;
			prodLast <= 1'b0;
		end
		else
		begin
			// Read data lands one cycle after its grant
			rdValid <= engGnt && !engWe;
			prodValid <= rdValid && state == mac;
			prodLast <= rdValid && capK == coefIdxT'(filterOrder);
			if (engGnt && !engWe)
				issueK <= issueK + coefIdxT'(1);
			if (rdValid)
				capK <= capK + coefIdxT'(1);
			case (state)
				idle:
					if (start)
					begin
						state <= loadCoef;
						issueK <= '0;
						capK <= '0;
						n <= '0;
					end
				loadCoef:
					// Last coefficient back, start the first output
					if (rdValid && capK == coefIdxT'(filterOrder))
					begin
						state <= mac;
						issueK <= '0;
						capK <= '0;
					end
				mac:
					if (prodValid && prodLast)
						state <= store;
				store:
					if (engGnt)
					begin
						issueK <= '0;
						capK <= '0;
						if (lenT'(n + lenT'(1)) == len)
							state <= residuPkg::finish;
						else
						begin
							n <= n + lenT'(1);
							state <= mac;
						end
					end
				residuPkg::finish: state <= idle;
				default: state <= idle;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (state == loadCoef && rdValid)
			coef[capK] <= ramRdata;
		// a[k] * x[n-k], one product behind the read
		if (state == mac && rdValid)
			product <= accT'(coef[capK]) * accT'(ramRdata);
		// Fresh sum per output
		if ((state == idle && start) || (state == store && engGnt))
			acc <= '0;
		else if (prodValid)
			acc <= acc + product;
	end

	// Writes only once every tap is read and summed
	assert property (@(posedge clk) disable iff (!rstN)
		engWe |-> state == store && issueDone && !rdValid && !prodValid);

endmodule

// File: logic/residuTop.sv
`timescale 1ns/1ps

module residuTop
	import residuPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic PSEL,
	input logic PENABLE,
	input logic PWRITE,
	input apbAddrT PADDR,
	input logic [31:0] PWDATA,
	output logic [31:0] PRDATA,
	output logic PREADY,
	output logic PSLVERR
);

	// Host port
	logic hostReq;
	logic hostGnt;
	memAddrT hostAddr;
	logic hostWe;
	sampleT hostWdata;
	// Engine port
	logic engReq;
	logic engGnt;
	memAddrT engAddr;
	logic engWe;
	sampleT engWdata;
	// RAM side
	logic ramEn;
	logic ramWe;
	memAddrT ramAddr;
	sampleT ramWdata;
	sampleT ramRdata;
	// Control
	logic start;
	logic busy;
	logic finish;
	memAddrT aBase;
	memAddrT xBase;
	memAddrT yBase;
	lenT len;

	apbRegs regs (
		.clk(clk), .rstN(rstN),
		.PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
		.PADDR(PADDR), .PWDATA(PWDATA),
		.hostGnt(hostGnt), .ramRdata(ramRdata), .busy(busy), .finish(finish),
		.PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
		.hostReq(hostReq), .hostAddr(hostAddr), .hostWe(hostWe), .hostWdata(hostWdata),
		.start(start), .aBase(aBase), .xBase(xBase), .yBase(yBase), .len(len)
	);

	residuEngine engine (
		.clk(clk), .rstN(rstN), .start(start),
		.aBase(aBase), .xBase(xBase), .yBase(yBase), .len(len),
		.engGnt(engGnt), .ramRdata(ramRdata),
		.engReq(engReq), .engAddr(engAddr), .engWe(engWe), .engWdata(engWdata),
		.busy(busy), .finish(finish)
	);

	memArbiter arbiter (
		.clk(clk), .rstN(rstN),
		.hostReq(hostReq), .hostAddr(hostAddr), .hostWe(hostWe), .hostWdata(hostWdata),
		.engReq(engReq), .engAddr(engAddr), .engWe(engWe), .engWdata(engWdata),
		.hostGnt(hostGnt), .engGnt(engGnt),
		.ramEn(ramEn), .ramWe(ramWe), .ramAddr(ramAddr), .ramWdata(ramWdata)
	);

	sampleRam ram (
		.clk(clk), .ramEn(ramEn), .ramWe(ramWe),
		.ramAddr(ramAddr), .ramWdata(ramWdata), .ramRdata(ramRdata)
	);

endmodule

// File: testbench/residuModel.svh
`ifndef residuModelSvh
`define residuModelSvh

////////////////////////////////////////////////////////////
// Random numbers
////////////////////////////////////////////////////////////

// Xorshift32, one step per call
function automatic logic [31:0] nextRand();
	rngState = rngState ^ (rngState << 13);
	rngState = rngState ^ (rngState >> 17);
	rngState = rngState ^ (rngState << 5);
	return rngState;
endfunction

// Sample or coefficient, full scale rails when extreme
function automatic sampleT randomSample(input logic extreme);
	logic [31:0] r;
	r = nextRand();
	if (extreme)
		return r[0] ? 16'sh7fff : 16'sh8000;
	// Eighth of full scale keeps most sums in range
	return sampleT'(r[15:0]) >>> 3;
endfunction

////////////////////////////////////////////////////////////
// Reference filter
////////////////////////////////////////////////////////////

// y[n] = sum a[k] * x[n-k], Q12 round, clamp to 16 bits
function automatic sampleT expectedOut(input int aAddr, input int xAddr, input int n);
	longint acc;
	longint rounded;
	acc = 0;
	for (int k = 0; k <= 10; k++)
		acc += longint'(shadow[aAddr + k]) * longint'(shadow[xAddr + n - k]);
	rounded = (acc + 64'sd2048) >>> 12;
	if (rounded > 64'sd32767)
		return 16'sh7fff;
	if (rounded < -64'sd32768)
		return 16'sh8000;
	return sampleT'(rounded);
endfunction

////////////////////////////////////////////////////////////
// APB host
////////////////////////////////////////////////////////////

// Entered and left 5 ns after a rising edge
task automatic transfer(input logic write, input apbAddrT addr, input logic [31:0] wdata,
	output logic [31:0] rdata, output logic err);
	int waitCycles;
	// Setup phase
	PSEL = 1'b1;
	PENABLE = 1'b0;
	PWRITE = write;
	PADDR = addr;
	PWDATA = wdata;
	@(posedge clk);
	#5;
	// Access phase, window accesses may stall on the arbiter
	PENABLE = 1'b1;
	waitCycles = 0;
	@(negedge clk);
	while (!PREADY && waitCycles < 64)
	begin
		@(negedge clk);
		waitCycles++;
	end
	if (!PREADY)
	begin
		timeouts++;
		$display("Timeout waiting for PREADY at address %h", addr);
	end
	rdata = PRDATA;
	err = PSLVERR;
	@(posedge clk);
	#5;
	PSEL = 1'b0;
	PENABLE = 1'b0;
endtask

task automatic writeApb(input apbAddrT addr, input logic [31:0] wdata, input logic expErr);
	logic [31:0] ignored;
	logic err;
	transfer(1'b1, addr, wdata, ignored, err);
	expectValue("PSLVERR", addr, 32'(err), 32'(expErr));
endtask

task automatic readApb(input apbAddrT addr, input logic expErr, output logic [31:0] rdata);
	logic err;
	transfer(1'b0, addr, 32'd0, rdata, err);
	expectValue("PSLVERR", addr, 32'(err), 32'(expErr));
endtask

`endif

// File: testbench/residuTb.sv
`timescale 1ns/1ps

module residuTb
	import residuPkg::*;
();

	logic clk = 1'b0;
	logic rstN;
	logic PSEL;
	logic PENABLE;
	logic PWRITE;
	apbAddrT PADDR;
	logic [31:0] PWDATA;
	logic [31:0] PRDATA;
	logic PREADY;
	logic PSLVERR;

	// What the host believes the sample memory holds
	sampleT shadow [memDepth];
	logic [31:0] rngState;
	int mismatches;
	int timeouts;
	int frameLen;

	`include "residuModel.svh"

	residuTop uut (
		.clk(clk), .rstN(rstN),
		.PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
		.PADDR(PADDR), .PWDATA(PWDATA),
		.PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR)
	);

	// 100 ns period
	always #50 clk = ~clk;

	task automatic expectValue(input string name, input apbAddrT addr,
		input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			mismatches++;
			$display("FAILED %s at %h got %h expected %h", name, addr, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Memory window helpers
	////////////////////////////////////////////////////////////

	function automatic apbAddrT windowAddr(input int word);
		return {1'b1, memAddrT'(word), 2'b00};
	endfunction

	// Upper PWDATA bits are junk the RAM must ignore
	task automatic memWrite(input int word, input sampleT value);
		logic [31:0] r;
		r = nextRand();
		writeApb(windowAddr(word), {r[31:16], value}, 1'b0);
		shadow[word] = value;
	endtask

	// Read back sign extended
	task automatic memCheck(input int word);
		logic [31:0] got;
		readApb(windowAddr(word), 1'b0, got);
		expectValue("PRDATA", windowAddr(word), got, {{16{shadow[word][15]}}, shadow[word]});
	endtask

	task automatic regCheck(input apbAddrT offset, input logic [31:0] value);
		logic [31:0] got;
		writeApb(offset, value, 1'b0);
		readApb(offset, 1'b0, got);
		expectValue("PRDATA", offset, got, value);
	endtask

	////////////////////////////////////////////////////////////
	// Behaviors
	////////////////////////////////////////////////////////////

	task automatic checkRegisters();
		for (int i = 0; i < 8; i++)
		begin
			regCheck(aBaseOffset, nextRand() & 32'h7ff);
			regCheck(xBaseOffset, nextRand() & 32'h7ff);
			regCheck(yBaseOffset, nextRand() & 32'h7ff);
			// Legal lengths only, 1 to 64
			regCheck(lenOffset, 32'd1 + (nextRand() % 32'd64));
		end
	endtask

	task automatic checkWindow();
		int words[$];
		int word;
		for (int i = 0; i < 32; i++)
		begin
			word = int'(nextRand() % 32'd2048);
			words.push_back(word);
			memWrite(word, sampleT'(nextRand()));
		end
		foreach (words[i])
			memCheck(words[i]);
	endtask

	task automatic checkErrors();
		logic [31:0] got;
		writeApb(lenOffset, 32'd20, 1'b0);
		writeApb(aBaseOffset, 32'h123, 1'b0);
		// Out of range lengths are refused
		writeApb(lenOffset, 32'd0, 1'b1);
		writeApb(lenOffset, 32'd65, 1'b1);
		readApb(lenOffset, 1'b0, got);
		expectValue("PRDATA", lenOffset, got, 32'd20);
		// Holes in the register map
		writeApb(14'h014, 32'h5a5, 1'b1);
		readApb(14'h020, 1'b1, got);
		readApb(14'h1ffc, 1'b1, got);
		readApb(aBaseOffset, 1'b0, got);
		expectValue("PRDATA", aBaseOffset, got, 32'h123);
	endtask

	// Polls CTRL until done
	task automatic waitDone();
		logic [31:0] ctrl;
		int polls;
		ctrl = '0;
		polls = 0;
		while (!ctrl[1] && polls < 2000)
		begin
			readApb(ctrlOffset, 1'b0, ctrl);
			polls++;
		end
		if (!ctrl[1])
		begin
			timeouts++;
			$display("Timeout waiting for the engine to finish a frame");
		end
		// Done set, busy already dropped
		expectValue("PRDATA", ctrlOffset, ctrl & 32'h3, 32'h2);
	endtask

	// Disjoint regions: a below 211, x from 290, y from 898, host traffic from 1600
	task automatic runFrame(input int len, input logic extreme);
		int aAddr;
		int xAddr;
		int yAddr;
		int word;
		logic [31:0] got;
		aAddr = int'(nextRand() % 32'd200);
		xAddr = 300 + int'(nextRand() % 32'd400);
		yAddr = 900 + int'(nextRand() % 32'd500);
		for (int k = 0; k <= 10; k++)
			memWrite(aAddr + k, randomSample(extreme));
		// Ten words of history below xAddr
		for (int i = -10; i < len; i++)
			memWrite(xAddr + i, randomSample(extreme));
		// Guards on both sides of the output block
		memWrite(yAddr - 2, sampleT'(nextRand()));
		memWrite(yAddr - 1, sampleT'(nextRand()));
		memWrite(yAddr + len, sampleT'(nextRand()));
		memWrite(yAddr + len + 1, sampleT'(nextRand()));
		writeApb(aBaseOffset, 32'(aAddr), 1'b0);
		writeApb(xBaseOffset, 32'(xAddr), 1'b0);
		writeApb(yBaseOffset, 32'(yAddr), 1'b0);
		writeApb(lenOffset, 32'(len), 1'b0);
		writeApb(ctrlOffset, 32'd1, 1'b0);
		// Second start lands on a running engine
		writeApb(ctrlOffset, 32'd1, 1'b1);
		// Host traffic fighting the engine for the RAM
		for (int i = 0; i < 6; i++)
		begin
			word = 1600 + int'(nextRand() % 32'd448);
			memWrite(word, sampleT'(nextRand()));
			memCheck(word);
		end
		waitDone();
		for (int n = 0; n < len; n++)
		begin
			readApb(windowAddr(yAddr + n), 1'b0, got);
			expectValue("PRDATA", windowAddr(yAddr + n), got,
				32'(expectedOut(aAddr, xAddr, n)));
		end
		// Nothing but y[0..len-1] may change
		memCheck(yAddr - 2);
		memCheck(yAddr - 1);
		memCheck(yAddr + len);
		memCheck(yAddr + len + 1);
		for (int k = 0; k <= 10; k++)
			memCheck(aAddr + k);
		for (int i = -10; i < len; i++)
			memCheck(xAddr + i);
	endtask

	////////////////////////////////////////////////////////////
	// Sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		rngState = 32'h5d73bfbd;
		mismatches = 0;
		timeouts = 0;
		rstN = 1'b0;
		PSEL = 1'b0;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
		PADDR = '0;
		PWDATA = '0;
		repeat (3) @(posedge clk);
		#5;
		rstN = 1'b1;
		checkRegisters();
		checkWindow();
		checkErrors();
		// Longest and shortest frame first
		for (int f = 0; f < 8; f++)
		begin
			if (f == 0)
				frameLen = 64;
			else if (f == 1)
				frameLen = 1;
			else
				frameLen = 1 + int'(nextRand() % 32'd64);
			runFrame(frameLen, 1'b0);
		end
		// Clamping at both rails
		runFrame(16, 1'b1);
		runFrame(40, 1'b1);
		$display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: files.f
+incdir+testbench
logic/residuPkg.sv
logic/sampleRam.sv
logic/memArbiter.sv
logic/apbRegs.sv
logic/residuEngine.sv
logic/residuTop.sv
testbench/residuTb.sv

// File: Makefile
SIM = obj_dir/residuSim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f files.f --top-module residuTb \
		-Mdir obj_dir -o residuSim

run: compile
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
